// ==== dhcp_defs.svh ====
// dhcp client constants
// payload lengths, byte positions inside the BOOTP frame, field values
// and the option codes seen by the builder and the parser
`ifndef DHCP_DEFS_SVH
`define DHCP_DEFS_SVH

// ------------------------------
// payload lengths in bytes
`define DHCP_DISCOVER_LEN 16'd244  // ends right after the message type option
`define DHCP_REQUEST_LEN  16'd256  // adds requested ip and server id

// ------------------------------
// byte positions in the payload
`define DHCP_XID_FIRST     9'd4    // transaction id, msb first
`define DHCP_XID_LAST      9'd7
`define DHCP_YIADDR_FIRST  9'd16   // offered address, four bytes
`define DHCP_CHADDR_FIRST  9'd28   // client mac, six bytes
`define DHCP_CHECK_BYTE    9'd34   // first byte past chaddr
`define DHCP_OPTIONS_START 9'd240  // magic cookie ends here

// ------------------------------
// field values
`define DHCP_OP_REPLY 8'h02        // BOOTREPLY

// message type option payload
`define DHCP_MSG_DISCOVER 8'h01
`define DHCP_MSG_OFFER    8'h02
`define DHCP_MSG_REQUEST  8'h03
`define DHCP_MSG_ACK      8'h05

// ------------------------------
// option code and length as one word
`define DHCP_OPT_MSG_TYPE  16'h3501  // option 53, one byte
`define DHCP_OPT_LEASE     16'h3304  // option 51, lease seconds
`define DHCP_OPT_SERVER_ID 16'h3604  // option 54, server address

// single byte options
`define DHCP_OPT_END 8'hFF
`define DHCP_OPT_PAD 8'h00

`endif

// ==== dhcp_pkg.sv ====
// dhcp client types
// state encodings of the two machines, the message kind and the
// two views of an option header
package dhcp_pkg;

  // ------------------------------
  // transmit machine
  typedef enum logic [2:0] {
    TX_IDLE     = 3'd0,  // waiting for tx_enable or a request
    TX_DISCOVER = 3'd1,  // discover queued, waiting for the udp layer
    TX_REQUEST  = 3'd2,  // request queued, waiting for the udp layer
    TX_SEND     = 3'd3   // streaming payload bytes
  } tx_state_e;

  // receive machine
  typedef enum logic [1:0] {
    RX_IDLE  = 2'd0,     // looking for the reply opcode
    RX_REPLY = 2'd1,     // inside a reply
    RX_DONE  = 2'd2      // ignore the rest of the payload
  } rx_state_e;

  // picks the payload length and the message type byte
  typedef enum logic {
    KIND_DISCOVER = 1'b0,
    KIND_REQUEST  = 1'b1
  } msg_kind_e;

  // ------------------------------
  // option header, code byte then length byte
  typedef struct packed {
    logic [7:0] code;
    logic [7:0] len;
  } dhcp_option_s;

  typedef union packed {
    logic [15:0]  word;  // compared against whole option codes
    dhcp_option_s f;
  } dhcp_option_u;

endpackage

// ==== dhcp_session_if.sv ====
// dhcp session state
// transaction id, accepted address and the request handover between
// the transmit builder and the receive parser
interface dhcp_session_if;

  logic [31:0] xid;            // transaction id, owned by the builder
  logic [31:0] ip_accept;      // offered address once the mac matched
  logic        send_request;   // OFFER seen, request wanted
  logic        request_taken;  // builder is in its send state

  modport tx (
    output xid,
    output request_taken,
    input  ip_accept,
    input  send_request
  );

  modport rx (
    input  xid,
    input  request_taken,
    output ip_accept,
    output send_request
  );

endinterface

// ==== dhcp_tx_builder.sv ====
// dhcp transmit side
// builds DHCPDISCOVER and DHCPREQUEST payloads for the udp layer one
// byte at a time and owns the transaction id
`include "dhcp_defs.svh"

module dhcp_tx_builder (
  input  logic        rx_clock,
  input  logic        state_reset,
  input  logic        tx_enable,      // start a discover, one cycle
  input  logic        udp_tx_enable,  // udp layer ready for our frame
  input  logic        udp_tx_active,  // udp layer takes a byte
  input  logic [47:0] local_mac,
  input  logic [31:0] remote_ip,      // server id sent in the request
  dhcp_session_if.tx  sess,
  output logic        dhcp_tx_request,
  output logic [7:0]  tx_data,
  output logic [15:0] length
);

  dhcp_pkg::tx_state_e state;
  dhcp_pkg::msg_kind_e kind;
  logic [8:0]  byte_no;    // index of the next byte to present
  logic [15:0] xid_count;
  logic        xid_frozen;
  logic [7:0]  next_byte;

  // ------------------------------
  // transaction id
  // counts freely until the first discover, then stays put
  always_ff @(posedge rx_clock) begin
    if (state_reset) begin
      xid_count  <= 16'd0;
      xid_frozen <= 1'b0;
    end else begin
      if (!xid_frozen)
        xid_count <= xid_count + 16'd1;
      if (state == dhcp_pkg::TX_DISCOVER)
        xid_frozen <= 1'b1;
    end
  end

  assign sess.xid           = {local_mac[15:0], xid_count};
  assign sess.request_taken = (state == dhcp_pkg::TX_SEND);  // lets the parser drop its flag

  // ------------------------------
  // payload byte for the current index
  always_comb begin
    case (byte_no)
      9'd0, 9'd1:              next_byte = 8'h01;  // op BOOTREQUEST, htype ethernet
      9'd2:                    next_byte = 8'h06;  // hlen
      `DHCP_XID_FIRST:         next_byte = sess.xid[31:24];
      `DHCP_XID_FIRST + 9'd1:  next_byte = sess.xid[23:16];
      `DHCP_XID_FIRST + 9'd2:  next_byte = sess.xid[15:8];
      `DHCP_XID_LAST:          next_byte = sess.xid[7:0];
      // chaddr
      `DHCP_CHADDR_FIRST:         next_byte = local_mac[47:40];
      `DHCP_CHADDR_FIRST + 9'd1:  next_byte = local_mac[39:32];
      `DHCP_CHADDR_FIRST + 9'd2:  next_byte = local_mac[31:24];
      `DHCP_CHADDR_FIRST + 9'd3:  next_byte = local_mac[23:16];
      `DHCP_CHADDR_FIRST + 9'd4:  next_byte = local_mac[15:8];
      `DHCP_CHADDR_FIRST + 9'd5:  next_byte = local_mac[7:0];
      // magic cookie
      9'd236: next_byte = 8'h63;
      9'd237: next_byte = 8'h82;
      9'd238: next_byte = 8'h53;
      9'd239: next_byte = 8'h63;
      `DHCP_OPTIONS_START: next_byte = 8'h35;  // message type option
      9'd241:              next_byte = 8'h01;
      9'd242: begin
        next_byte = (kind == dhcp_pkg::KIND_DISCOVER) ? `DHCP_MSG_DISCOVER
                                                      : `DHCP_MSG_REQUEST;
      end
      9'd243: begin                            // a discover ends here
        next_byte = (kind == dhcp_pkg::KIND_DISCOVER) ? `DHCP_OPT_END : 8'h32;
      end
      9'd244: next_byte = 8'h04;               // requested ip length
      9'd245: next_byte = sess.ip_accept[31:24];
      9'd246: next_byte = sess.ip_accept[23:16];
      9'd247: next_byte = sess.ip_accept[15:8];
      9'd248: next_byte = sess.ip_accept[7:0];
      9'd249: next_byte = 8'h36;               // server identifier
      9'd250: next_byte = 8'h04;
      9'd251: next_byte = remote_ip[31:24];
      9'd252: next_byte = remote_ip[23:16];
      9'd253: next_byte = remote_ip[15:8];
      9'd254: next_byte = remote_ip[7:0];
      9'd255: next_byte = `DHCP_OPT_END;
      default: next_byte = 8'h00;              // hops, secs, flags, addresses, sname, file
    endcase
  end

  // ------------------------------
  // message FSM
  always_ff @(posedge rx_clock) begin
    if (state_reset) begin
      state           <= dhcp_pkg::TX_IDLE;
      dhcp_tx_request <= 1'b0;
      byte_no         <= 9'd0;
    end else begin
      case (state)
        dhcp_pkg::TX_IDLE: begin
          byte_no <= 9'd0;
          if (tx_enable) begin                 // a discover wins over a pending request
            state           <= dhcp_pkg::TX_DISCOVER;
            kind            <= dhcp_pkg::KIND_DISCOVER;
            length          <= `DHCP_DISCOVER_LEN;
            dhcp_tx_request <= 1'b1;
          end else if (sess.send_request) begin
            state           <= dhcp_pkg::TX_REQUEST;
            kind            <= dhcp_pkg::KIND_REQUEST;
            length          <= `DHCP_REQUEST_LEN;
            dhcp_tx_request <= 1'b1;
          end
        end

        dhcp_pkg::TX_DISCOVER, dhcp_pkg::TX_REQUEST: begin
          // byte 0 has to sit on tx_data before the first active cycle
          if (udp_tx_enable) begin
            tx_data <= next_byte;
            byte_no <= 9'd1;
            state   <= dhcp_pkg::TX_SEND;
          end
        end

        dhcp_pkg::TX_SEND: begin
          if ({7'd0, byte_no} < length) begin
            if (udp_tx_active) begin           // tx_data holds while inactive
              tx_data <= next_byte;
              byte_no <= byte_no + 9'd1;
            end
          end else begin
            state           <= dhcp_pkg::TX_IDLE;  // whole payload handed over
            dhcp_tx_request <= 1'b0;
          end
        end

        default: state <= dhcp_pkg::TX_IDLE;
      endcase
    end
  end

endmodule

// ==== dhcp_rx_parser.sv ====
// dhcp receive side
// walks BOOTREPLY payloads meant for this client, keeps the offered
// address, asks for a request on an OFFER and reads lease time and
// server id from the options of an ACK
`include "dhcp_defs.svh"

module dhcp_rx_parser (
  input  logic        rx_clock,
  input  logic        state_reset,
  input  logic [7:0]  rx_data,
  input  logic        rx_enable,       // byte valid
  input  logic        dhcp_rx_active,  // high for the whole udp payload
  input  logic [47:0] local_mac,
  dhcp_session_if.rx  sess,
  output logic [31:0] lease,           // lease time in seconds
  output logic [31:0] server_ip,
  output logic        dhcp_success,
  output logic        dhcp_failed
);

  dhcp_pkg::rx_state_e    state;
  dhcp_pkg::dhcp_option_u option;  // header of the current option
  logic [8:0]  byte_no;            // also serves as the option walk step
  logic [31:0] offer_ip;           // yiaddr until the mac is checked
  logic [47:0] target_mac;         // chaddr of the reply
  logic [23:0] opt_data;           // leading bytes of a four byte option
  logic [7:0]  skip;               // bytes left in an unknown option
  logic [7:0]  xid_byte;

  // expected xid byte, byte 4 is the msb
  assign xid_byte = sess.xid[8 * (3 - byte_no[1:0]) +: 8];

  always_ff @(posedge rx_clock) begin
    if (state_reset) begin
      state             <= dhcp_pkg::RX_IDLE;
      sess.send_request <= 1'b0;
      sess.ip_accept    <= 32'd0;
      dhcp_success      <= 1'b0;
      dhcp_failed       <= 1'b0;
    end else begin
      if (sess.request_taken)
        sess.send_request <= 1'b0;  // builder started sending
      if (!rx_enable) begin
        dhcp_success <= 1'b0;
        dhcp_failed  <= 1'b0;
      end

      if (!dhcp_rx_active)
        state <= dhcp_pkg::RX_IDLE;  // payload over
      else if (rx_enable) begin
        case (state)
          dhcp_pkg::RX_IDLE: begin
            byte_no <= 9'd1;
            if (rx_data == `DHCP_OP_REPLY)
              state <= dhcp_pkg::RX_REPLY;
          end

          dhcp_pkg::RX_REPLY: begin
            byte_no <= byte_no + 9'd1;  // steps below may redirect
            // ------------------------------
            // fixed header
            if (byte_no < `DHCP_OPTIONS_START) begin
              if (byte_no >= `DHCP_XID_FIRST && byte_no <= `DHCP_XID_LAST &&
                  rx_data != xid_byte)
                state <= dhcp_pkg::RX_DONE;  // another client's transaction
              if (byte_no >= `DHCP_YIADDR_FIRST && byte_no < `DHCP_YIADDR_FIRST + 9'd4)
                offer_ip <= {offer_ip[23:0], rx_data};
              if (byte_no >= `DHCP_CHADDR_FIRST && byte_no < `DHCP_CHECK_BYTE)
                target_mac <= {target_mac[39:0], rx_data};
              if (byte_no == `DHCP_CHECK_BYTE) begin
                if (target_mac != local_mac)
                  state <= dhcp_pkg::RX_DONE;
                else
                  sess.ip_accept <= offer_ip;  // reply is ours
              end
            end else begin
              // ------------------------------
              // option walk
              case (byte_no)
                `DHCP_OPTIONS_START: begin    // code byte
                  option.f.code <= rx_data;
                  if (rx_data == `DHCP_OPT_END) begin
                    dhcp_success <= 1'b1;
                    dhcp_failed  <= 1'b0;
                    state        <= dhcp_pkg::RX_DONE;
                  end else if (rx_data == `DHCP_OPT_PAD)
                    byte_no <= `DHCP_OPTIONS_START;  // pad has no length
                end

                `DHCP_OPTIONS_START + 9'd1: begin  // length byte
                  option.f.len <= rx_data;
                  if (rx_data == 8'd0)
                    byte_no <= `DHCP_OPTIONS_START;
                end

                `DHCP_OPTIONS_START + 9'd2: begin  // first data byte
                  skip     <= option.f.len;
                  opt_data <= {opt_data[15:0], rx_data};
                  if (option.word == `DHCP_OPT_MSG_TYPE) begin
                    byte_no <= `DHCP_OPTIONS_START;
                    if (rx_data == `DHCP_MSG_OFFER) begin
                      sess.send_request <= 1'b1;
                      state             <= dhcp_pkg::RX_DONE;
                    end else if (rx_data != `DHCP_MSG_ACK) begin
                      dhcp_failed  <= 1'b1;
                      dhcp_success <= 1'b0;
                      state        <= dhcp_pkg::RX_DONE;
                    end
                  end else if (option.word != `DHCP_OPT_LEASE &&
                               option.word != `DHCP_OPT_SERVER_ID) begin
                    // unknown option
                    byte_no <= (option.f.len == 8'd1) ? `DHCP_OPTIONS_START
                                                      : `DHCP_OPTIONS_START + 9'd9;
                  end
                end

                `DHCP_OPTIONS_START + 9'd3, `DHCP_OPTIONS_START + 9'd4:
                  opt_data <= {opt_data[15:0], rx_data};

                `DHCP_OPTIONS_START + 9'd5: begin  // last of four bytes
                  byte_no <= `DHCP_OPTIONS_START;
                  if (option.word == `DHCP_OPT_LEASE)
                    lease <= {opt_data, rx_data};
                  else
                    server_ip <= {opt_data, rx_data};
                end

                `DHCP_OPTIONS_START + 9'd9: begin  // skipping, two bytes already gone
                  if (skip == 8'd2)
                    byte_no <= `DHCP_OPTIONS_START;
                  else begin
                    skip    <= skip - 8'd1;
                    byte_no <= byte_no;
                  end
                end

                default: ;
              endcase
            end
          end

          default: ;  // done, wait for dhcp_rx_active to drop
        endcase
      end
    end
  end

endmodule

// ==== dhcp_client.sv ====
// dhcp client top level
// the transmit builder and the receive parser share session state
// through one interface, the outside sees plain ports
module dhcp_client (
  input  logic        rx_clock,
  input  logic        state_reset,
  // receive
  input  logic [7:0]  rx_data,
  input  logic        rx_enable,
  input  logic        dhcp_rx_active,
  // transmit
  input  logic        tx_enable,
  input  logic        udp_tx_enable,
  input  logic        udp_tx_active,
  // addresses
  input  logic [47:0] local_mac,
  input  logic [31:0] remote_ip,
  output logic        dhcp_tx_request,
  output logic [7:0]  tx_data,
  output logic [15:0] length,
  output logic [31:0] ip_accept,     // address offered to us
  output logic [31:0] lease,
  output logic [31:0] server_ip,
  output logic        dhcp_success,
  output logic        dhcp_failed
);

  dhcp_session_if sess ();

  dhcp_tx_builder tx_builder_i (
    .rx_clock        (rx_clock),
    .state_reset     (state_reset),
    .tx_enable       (tx_enable),
    .udp_tx_enable   (udp_tx_enable),
    .udp_tx_active   (udp_tx_active),
    .local_mac       (local_mac),
    .remote_ip       (remote_ip),
    .sess            (sess.tx),
    .dhcp_tx_request (dhcp_tx_request),
    .tx_data         (tx_data),
    .length          (length)
  );

  dhcp_rx_parser rx_parser_i (
    .rx_clock       (rx_clock),
    .state_reset    (state_reset),
    .rx_data        (rx_data),
    .rx_enable      (rx_enable),
    .dhcp_rx_active (dhcp_rx_active),
    .local_mac      (local_mac),
    .sess           (sess.rx),
    .lease          (lease),
    .server_ip      (server_ip),
    .dhcp_success   (dhcp_success),
    .dhcp_failed    (dhcp_failed)
  );

  assign ip_accept = sess.ip_accept;

endmodule

// ==== tb_dhcp_clock.sv ====
// testbench clock and reset
// period of 4, state_reset held for the first 5 rising edges
module tb_dhcp_clock (
  output logic rx_clock,
  output logic state_reset
);

  initial begin
    rx_clock = 1'b0;
    forever #2 rx_clock = ~rx_clock;
  end

  initial begin
    state_reset = 1'b1;
    repeat (5) @(posedge rx_clock);
    #1 state_reset = 1'b0;  // released like any other input
  end

endmodule

// ==== tb_dhcp.sv ====
// dhcp client testbench
// discover, offer, request, ack and nak exchanges against the client,
// every transmitted byte checked against a reference model
`include "dhcp_defs.svh"

module tb_dhcp;

  logic        rx_clock;
  logic        state_reset;
  logic [7:0]  rx_data;
  logic        rx_enable;
  logic        dhcp_rx_active;
  logic        tx_enable;
  logic        udp_tx_enable;
  logic        udp_tx_active;
  logic [47:0] local_mac;
  logic [31:0] remote_ip;
  logic        dhcp_tx_request;
  logic [7:0]  tx_data;
  logic [15:0] length;
  logic [31:0] ip_accept;
  logic [31:0] lease;
  logic [31:0] server_ip;
  logic        dhcp_success;
  logic        dhcp_failed;

  int          errors = 0;
  int          timeouts = 0;
  logic [31:0] lcg_state = 32'd93;
  logic [7:0]  pkt[$];             // rx payload being built
  logic [7:0]  tx_bytes[$];        // captured and not yet compared
  bit          cap_armed = 1'b0;   // next udp_tx_enable opens a frame
  bit          streaming = 1'b0;
  bit          grab;
  bit          seen;               // result of the last wait
  bit          xid_known = 1'b0;
  bit          cmp_request = 1'b0; // kind of the frame in flight
  int          cmp_index = 0;
  logic [31:0] cmp_xid = 32'd0;
  logic [31:0] cmp_ip = 32'd0;
  logic [31:0] offer;
  logic [7:0]  got;
  logic [7:0]  held;               // last byte taken from tx_data

  tb_dhcp_clock clock_gen_i (.rx_clock(rx_clock), .state_reset(state_reset));

  dhcp_client dhcp_client_i (.*);

  // ------------------------------
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // payload byte idx of a discover or a request
  function automatic logic [7:0] tb_expected_byte(input int idx, input bit is_request,
      input logic [31:0] xid, input logic [31:0] ip_acc, input logic [31:0] srv);
    logic [31:0] cookie;
    cookie = 32'h6382_5363;
    if (idx == 0 || idx == 1) return 8'h01;          // op, htype
    if (idx == 2) return 8'h06;
    if (idx >= 4 && idx <= 7) return xid[8 * (7 - idx) +: 8];
    if (idx >= 28 && idx <= 33) return local_mac[8 * (33 - idx) +: 8];
    if (idx >= 236 && idx <= 239) return cookie[8 * (239 - idx) +: 8];
    if (idx == 240) return 8'h35;
    if (idx == 241) return 8'h01;
    if (idx == 242) return is_request ? 8'h03 : 8'h01;
    if (!is_request) return (idx == 243) ? 8'hff : 8'h00;
    if (idx == 243) return 8'h32;                    // requested ip
    if (idx == 244 || idx == 250) return 8'h04;
    if (idx >= 245 && idx <= 248) return ip_acc[8 * (248 - idx) +: 8];
    if (idx == 249) return 8'h36;                    // server id
    if (idx >= 251 && idx <= 254) return srv[8 * (254 - idx) +: 8];
    return (idx == 255) ? 8'hff : 8'h00;
  endfunction

  task automatic check_value(input string name, input logic [47:0] actual,
                             input logic [47:0] expected);
    if (actual !== expected) begin
      $display("MISMATCH %s: got %h, expected %h at %0t", name, actual, expected, $time);
      errors++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("ERROR: no %s within the cycle limit at %0t", what, $time);
    timeouts++;
  endtask

  // sel 0 dhcp_tx_request, 1 dhcp_success, 2 dhcp_failed, else state_reset
  task automatic wait_for(input int sel, input logic level, input int limit);
    logic v;
    int   n;
    seen = 1'b0;
    n = 0;
    while (!seen && n < limit) begin
      @(negedge rx_clock);                 // outputs settled
      case (sel)
        0: v = dhcp_tx_request;
        1: v = dhcp_success;
        2: v = dhcp_failed;
        default: v = state_reset;
      endcase
      seen = (v === level);
      n++;
    end
    @(posedge rx_clock);
    #1;
  endtask

  // ------------------------------
  // udp side of one transmit frame
  task automatic run_frame(input bit gaps, input int n_bytes);
    logic [31:0] r;
    int          left;
    int          guard;
    r = lcg_next();
    repeat (r[1:0]) begin                  // udp layer answers late
      @(posedge rx_clock);
      #1;
    end
    cmp_index = 0;
    cap_armed = 1'b1;
    udp_tx_enable = 1'b1;
    @(posedge rx_clock);
    #1;
    udp_tx_enable = 1'b0;
    left = n_bytes - 1;                    // byte 0 came with the enable
    guard = 0;
    while (left > 0 && guard < 4 * n_bytes) begin
      r = lcg_next();
      udp_tx_active = !(gaps && r[31:30] == 2'b00);  // one cycle in four idle
      if (udp_tx_active)
        left--;
      guard++;
      @(posedge rx_clock);
      #1;
    end
    udp_tx_active = 1'b0;
    wait_for(0, 1'b0, 8);
    if (!seen)
      report_timeout("drop of dhcp_tx_request after the frame");
    streaming = 1'b0;
    check_value("frame byte count", cmp_index, n_bytes);
  endtask

  task automatic send_discover(input bit gaps);
    cmp_request = 1'b0;
    tx_enable = 1'b1;                      // single cycle pulse
    @(posedge rx_clock);
    #1;
    tx_enable = 1'b0;
    wait_for(0, 1'b1, 10);
    if (!seen)
      report_timeout("dhcp_tx_request after tx_enable");
    else begin
      check_value("length", length, `DHCP_DISCOVER_LEN);
      run_frame(gaps, 244);
    end
  endtask

  task automatic add_option(input logic [7:0] code, input logic [7:0] len,
                            input logic [31:0] data);
    int i;
    pkt.push_back(code);
    pkt.push_back(len);
    for (i = len - 1; i >= 0; i--)
      pkt.push_back(data[8 * i +: 8]);   // msb first
  endtask

  // BOOTREPLY header plus the message type option
  task automatic begin_reply(input logic [31:0] xid, input logic [47:0] mac,
                             input logic [31:0] yiaddr, input logic [7:0] msg);
    int i;
    pkt.delete();
    for (i = 0; i < 240; i++)
      pkt.push_back(8'h00);
    pkt[0] = `DHCP_OP_REPLY;
    pkt[1] = 8'h01;
    pkt[2] = 8'h06;
    for (i = 0; i < 4; i++) begin
      pkt[4 + i]   = xid[8 * (3 - i) +: 8];
      pkt[16 + i]  = yiaddr[8 * (3 - i) +: 8];
      pkt[236 + i] = tb_expected_byte(236 + i, 1'b0, 32'd0, 32'd0, 32'd0);  // cookie
    end
    for (i = 0; i < 6; i++)
      pkt[28 + i] = mac[8 * (5 - i) +: 8];
    add_option(8'h35, 8'd1, {24'd0, msg});
  endtask

  task automatic send_packet();
    int i;
    for (i = 0; i < pkt.size(); i++) begin
      rx_data        = pkt[i];
      rx_enable      = 1'b1;
      dhcp_rx_active = 1'b1;
      @(posedge rx_clock);
      #1;
    end
    dhcp_rx_active = 1'b0;                 // rx_enable stays up so the flags survive
    rx_data        = 8'h00;
    @(posedge rx_clock);
    #1;
  endtask

  // ------------------------------
  // tx_data one cycle after each byte event
  always @(posedge rx_clock) begin
    grab = (cap_armed && udp_tx_enable) || (streaming && udp_tx_active);
    if (cap_armed && udp_tx_enable) begin
      cap_armed = 1'b0;
      streaming = 1'b1;
    end
    if (grab) begin
      @(negedge rx_clock);
      tx_bytes.push_back(tx_data);
      held = tx_data;
    end else if (streaming) begin
      @(negedge rx_clock);                 // no byte taken so tx_data holds
      check_value("tx_data", tx_data, held);
    end
  end

  // compare against the reference
  always @(posedge rx_clock) begin
    while (tx_bytes.size() > 0) begin
      got = tx_bytes.pop_front();
      if (!xid_known && cmp_index >= 4 && cmp_index <= 7) begin
        cmp_xid[8 * (7 - cmp_index) +: 8] = got;  // first discover defines the xid
        if (cmp_index == 7) begin
          xid_known = 1'b1;
          check_value("xid upper half", cmp_xid[31:16], local_mac[15:0]);
        end
      end
      check_value("tx_data", got,
                  tb_expected_byte(cmp_index, cmp_request, cmp_xid, cmp_ip, remote_ip));
      cmp_index++;
    end
  end

  // ------------------------------
  initial begin
    rx_data        = 8'h00;
    rx_enable      = 1'b0;
    dhcp_rx_active = 1'b0;
    tx_enable      = 1'b0;
    udp_tx_enable  = 1'b0;
    udp_tx_active  = 1'b0;
    local_mac      = 48'h02_1a_2b_3c_4d_5e;
    remote_ip      = 32'hc0a8_0001;
    wait_for(3, 1'b0, 20);
    if (!seen)
      report_timeout("release of state_reset");

    // discover after reset
    check_value("dhcp_tx_request", dhcp_tx_request, 1'b0);
    check_value("dhcp_success", dhcp_success, 1'b0);
    send_discover(1'b0);

    // a matching offer makes the client send a request
    offer = lcg_next();
    begin_reply(cmp_xid, local_mac, offer, `DHCP_MSG_OFFER);
    pkt.push_back(`DHCP_OPT_END);
    send_packet();
    check_value("ip_accept", ip_accept, offer);
    wait_for(0, 1'b1, 40);
    if (!seen)
      report_timeout("request after the offer");
    else begin
      check_value("length", length, `DHCP_REQUEST_LEN);
      cmp_request = 1'b1;
      cmp_ip = offer;
      run_frame(1'b1, 256);
    end

    // offers for another transaction and for another client
    begin_reply(cmp_xid ^ 32'h1, local_mac, ~offer, `DHCP_MSG_OFFER);
    pkt.push_back(`DHCP_OPT_END);
    send_packet();
    check_value("ip_accept", ip_accept, offer);
    wait_for(0, 1'b1, 40);
    if (seen) begin
      $display("ERROR: request sent for an offer with a foreign transaction id");
      errors++;
    end
    begin_reply(cmp_xid, local_mac ^ 48'h1, ~offer, `DHCP_MSG_OFFER);
    pkt.push_back(`DHCP_OPT_END);
    send_packet();
    check_value("ip_accept", ip_accept, offer);
    wait_for(0, 1'b1, 40);
    if (seen) begin
      $display("ERROR: request sent for an offer to another client");
      errors++;
    end

    // ack with pad, host name, lease and server id
    begin_reply(cmp_xid, local_mac, offer, `DHCP_MSG_ACK);
    pkt.push_back(`DHCP_OPT_PAD);
    add_option(8'h0c, 8'd3, 32'h0064_6576);  // skipped by length
    add_option(8'h33, 8'd4, 32'h0001_5180);
    add_option(8'h36, 8'd4, 32'hc0a8_00fe);
    pkt.push_back(`DHCP_OPT_END);
    send_packet();
    wait_for(1, 1'b1, 10);
    if (!seen)
      report_timeout("dhcp_success after the ack");
    check_value("lease", lease, 32'h0001_5180);
    check_value("server_ip", server_ip, 32'hc0a8_00fe);
    check_value("dhcp_failed", dhcp_failed, 1'b0);

    // nak followed by rx_enable low to clear both flags
    rx_enable = 1'b0;
    repeat (2) begin
      @(posedge rx_clock);
      #1;
    end
    check_value("dhcp_success", dhcp_success, 1'b0);
    begin_reply(cmp_xid, local_mac, offer, 8'h06);
    pkt.push_back(`DHCP_OPT_END);
    send_packet();
    wait_for(2, 1'b1, 10);
    if (!seen)
      report_timeout("dhcp_failed after the nak");
    check_value("dhcp_success", dhcp_success, 1'b0);
    rx_enable = 1'b0;
    repeat (2) begin
      @(posedge rx_clock);
      #1;
    end
    check_value("dhcp_failed", dhcp_failed, 1'b0);
    check_value("dhcp_success", dhcp_success, 1'b0);

    // discover under back-pressure
    send_discover(1'b1);

    repeat (4) @(posedge rx_clock);
    $display("%0d errors, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule

// ==== src.f ====
+incdir+.
dhcp_pkg.sv
dhcp_session_if.sv
dhcp_tx_builder.sv
dhcp_rx_parser.sv
dhcp_client.sv
tb_dhcp_clock.sv
tb_dhcp.sv

// ==== Bender.yml ====
package:
  name: dhcp_client

sources:
  - include_dirs:
      - .
    files:
      - dhcp_pkg.sv
      - dhcp_session_if.sv
      - dhcp_tx_builder.sv
      - dhcp_rx_parser.sv
      - dhcp_client.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_dhcp_clock.sv
      - tb_dhcp.sv
